// File: design/adc_capture_pkg.sv
/* Default sizes and shared encodings for the ADC frame capture design.
   FRAME_LENGTH must be a multiple of 4 and fit in 2**BUFFER_ADDR_WIDTH bytes. */

package adc_capture_pkg;

    // Bytes per captured frame
    parameter int FRAME_LENGTH_DEFAULT      = 32;
    // Byte address width of the frame memory
    parameter int BUFFER_ADDR_WIDTH_DEFAULT = 5;
    // clk cycles per SPI clock half period
    parameter int SCLK_DIV_DEFAULT          = 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_SHIFT,
        RX_GAP
    } rx_state_e;

    // Register word offsets inside the register window
    typedef enum logic [1:0] {
        REG_CONTROL     = 2'd0,
        REG_STATUS      = 2'd1,
        REG_FRAME_COUNT = 2'd2
    } wb_reg_e;

    parameter int CTRL_START_BIT = 0;
    parameter int CTRL_CLEAR_BIT = 1;

    parameter int STAT_READY_BIT = 0;
    parameter int STAT_BUSY_BIT  = 1;

endpackage

// File: design/buffer_rd_if.sv
/* Word read path and frame-ready handshake between host port and frame buffer.
   rd_data is valid one cycle after rd_en. */

`timescale 1ns/1ps

interface buffer_rd_if #(
    parameter int WORD_ADDR_WIDTH = 3
);

    logic                       rd_en;
    logic [WORD_ADDR_WIDTH-1:0] rd_addr;
    logic [31:0]                rd_data;
    logic                       frame_ready;
    logic                       frame_clear;

    modport host (output rd_en, output rd_addr, output frame_clear,
                  input rd_data, input frame_ready);

    modport buffer (input rd_en, input rd_addr, input frame_clear,
                    output rd_data, output frame_ready);

endinterface

// File: design/spi_sample_rx.sv
/* SPI master for one fixed-length frame, MSB first, sclk idle high, sampled on rising edge.
   No ADC configuration or DOUT/RDY handling; start is ignored while busy. */

`timescale 1ns/1ps

module spi_sample_rx
    import adc_capture_pkg::*;
#(
    parameter int FRAME_LENGTH = FRAME_LENGTH_DEFAULT,
    parameter int SCLK_DIV     = SCLK_DIV_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       sdi,
    output logic       sclk,
    output logic       cs_n,
    output logic       busy,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       byte_first
);

    localparam int DIV_WIDTH  = $clog2(SCLK_DIV + 1);
    localparam int BYTE_WIDTH = $clog2(FRAME_LENGTH + 1);

    rx_state_e             state;
    logic [DIV_WIDTH-1:0]  div_cnt;
    logic [2:0]            bit_cnt;
    logic [BYTE_WIDTH-1:0] byte_cnt;
    logic [7:0]            shift_reg;
    logic                  half_done;
    logic                  rise_edge;

    assign half_done = (state == RX_SHIFT) && (div_cnt == SCLK_DIV - 1);
    // sclk is low now, so this half period ends with a rising edge
    assign rise_edge = half_done && !sclk;

    always_ff @(posedge clk) begin
        byte_valid <= 1'b0;
        if (rst) begin
            state      <= RX_IDLE;
            cs_n       <= 1'b1;
            sclk       <= 1'b1;
            busy       <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            byte_first <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (start) begin
                        state    <= RX_SHIFT;
                        cs_n     <= 1'b0;
                        busy     <= 1'b1;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                end
                RX_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (rise_edge) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            byte_valid <= 1'b1;
                            byte_first <= (byte_cnt == 0);
                            byte_cnt   <= byte_cnt + 1'b1;
                            if (byte_cnt == FRAME_LENGTH - 1) begin
                                state <= RX_GAP;
                            end
                        end
                    end
                end
                RX_GAP: begin
                    // Release chip select one cycle after the last byte
                    cs_n  <= 1'b1;
                    busy  <= 1'b0;
                    state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Shift register and output byte
    always_ff @(posedge clk) begin
        if (rise_edge) begin
            shift_reg <= {shift_reg[6:0], sdi};
            if (bit_cnt == 3'd7) begin
                byte_data <= {shift_reg[6:0], sdi};
            end
        end
    end

endmodule

// File: design/frame_buffer.sv
/* Byte-wide frame memory, always accepts input bytes, word reads are big-endian.
   Read latency 1; frame_ready set takes priority over frame_clear. */

`timescale 1ns/1ps

module frame_buffer #(
    parameter int FRAME_LENGTH      = 32,
    parameter int BUFFER_ADDR_WIDTH = 5
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       byte_first,
    buffer_rd_if.buffer rd
);

    logic [7:0] mem [0:2**BUFFER_ADDR_WIDTH-1];

    logic [BUFFER_ADDR_WIDTH-1:0] wr_addr;
    logic [BUFFER_ADDR_WIDTH-1:0] wr_sel;
    logic [BUFFER_ADDR_WIDTH-1:0] rd_base;
    logic                         last_byte;

    // First byte of a frame always lands at address 0
    assign wr_sel = byte_first ? '0 : wr_addr;

    assign last_byte = byte_valid && (wr_sel == FRAME_LENGTH - 1);

    // Write address, wraps at the end of the frame
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (byte_valid) begin
            if (wr_sel == FRAME_LENGTH - 1) begin
                wr_addr <= '0;
            end else begin
                wr_addr <= wr_sel + 1'b1;
            end
        end
    end

    // Byte write port
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            mem[wr_sel] <= byte_data;
        end
    end

    // Byte address of the first byte in the requested word
    assign rd_base = {rd.rd_addr, 2'b00};

    // Word read port, lowest byte address in the top byte
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.rd_data <= {
                mem[rd_base],
                mem[rd_base + 2'd1],
                mem[rd_base + 2'd2],
                mem[rd_base + 2'd3]
            };
        end
    end

    // Frame-ready flag
    always_ff @(posedge clk) begin
        if (rst) begin
            rd.frame_ready <= 1'b0;
        end else if (last_byte) begin
            rd.frame_ready <= 1'b1;
        end else if (rd.frame_clear) begin
            rd.frame_ready <= 1'b0;
        end
    end

endmodule

// File: design/wb_frame_port.sv
/* Wishbone classic slave with fixed ack latency of 2, SEL ignored, whole-word writes.
   Top address bit selects register window (1) or buffer window (0). */

`timescale 1ns/1ps

module wb_frame_port
    import adc_capture_pkg::*;
#(
    parameter int BUFFER_ADDR_WIDTH = BUFFER_ADDR_WIDTH_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [BUFFER_ADDR_WIDTH-2:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    output logic                         start,
    input  logic                         busy,
    buffer_rd_if.host                    rd
);

    logic                         req_new;
    logic                         pending;
    logic                         reg_win;
    logic [BUFFER_ADDR_WIDTH-3:0] reg_sel;
    logic                         ctrl_wr;
    logic [31:0]                  reg_rdata;
    logic                         ready_q;
    logic [7:0]                   frame_count;

    // New request, not already in progress or just acked
    assign req_new = wb_cyc && wb_stb && !pending && !wb_ack;

    assign reg_win = wb_adr[BUFFER_ADDR_WIDTH-2];
    assign reg_sel = wb_adr[BUFFER_ADDR_WIDTH-3:0];
    assign ctrl_wr = pending && wb_we && reg_win && (reg_sel == REG_CONTROL);

    // Buffer read goes out on the first cycle of the access
    assign rd.rd_en   = req_new && !wb_we && !reg_win;
    assign rd.rd_addr = wb_adr[BUFFER_ADDR_WIDTH-3:0];

    always_comb begin
        reg_rdata = '0;
        if (reg_sel == REG_STATUS) begin
            reg_rdata[STAT_READY_BIT] = rd.frame_ready;
            reg_rdata[STAT_BUSY_BIT]  = busy;
        end else if (reg_sel == REG_FRAME_COUNT) begin
            reg_rdata[7:0] = frame_count;
        end
    end

    // Two-cycle access sequence and control pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            pending        <= 1'b0;
            wb_ack         <= 1'b0;
            start          <= 1'b0;
            rd.frame_clear <= 1'b0;
        end else begin
            pending        <= req_new;
            wb_ack         <= pending;
            start          <= ctrl_wr && wb_dat_w[CTRL_START_BIT];
            rd.frame_clear <= ctrl_wr && wb_dat_w[CTRL_CLEAR_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (pending) begin
            wb_dat_r <= reg_win ? reg_rdata : rd.rd_data;
        end
    end

    // Completed frames, counted on rising frame_ready
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q     <= 1'b0;
            frame_count <= '0;
        end else begin
            ready_q <= rd.frame_ready;
            if (rd.frame_ready && !ready_q) begin
                frame_count <= frame_count + 8'd1;
            end
        end
    end

endmodule

// File: design/adc_capture_top.sv
/* ADC frame capture: SPI receive, frame buffer and Wishbone host port.
   FRAME_LENGTH must be a multiple of 4 and at most 2**BUFFER_ADDR_WIDTH. */

`timescale 1ns/1ps

module adc_capture_top
    import adc_capture_pkg::*;
#(
    parameter int FRAME_LENGTH      = FRAME_LENGTH_DEFAULT,
    parameter int BUFFER_ADDR_WIDTH = BUFFER_ADDR_WIDTH_DEFAULT,
    parameter int SCLK_DIV          = SCLK_DIV_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [BUFFER_ADDR_WIDTH-2:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    output logic                         sclk,
    output logic                         cs_n,
    input  logic                         sdi
);

    logic       start;
    logic       busy;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       byte_first;

    buffer_rd_if #(.WORD_ADDR_WIDTH(BUFFER_ADDR_WIDTH - 2)) rd_bus ();

    spi_sample_rx #(.FRAME_LENGTH(FRAME_LENGTH), .SCLK_DIV(SCLK_DIV)) u_rx (
        .clk(clk), .rst(rst), .start(start), .sdi(sdi),
        .sclk(sclk), .cs_n(cs_n), .busy(busy),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_first(byte_first)
    );

    frame_buffer #(.FRAME_LENGTH(FRAME_LENGTH), .BUFFER_ADDR_WIDTH(BUFFER_ADDR_WIDTH)) u_buf (
        .clk(clk), .rst(rst),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_first(byte_first),
        .rd(rd_bus.buffer)
    );

    wb_frame_port #(.BUFFER_ADDR_WIDTH(BUFFER_ADDR_WIDTH)) u_wb (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .start(start), .busy(busy), .rd(rd_bus.host)
    );

endmodule

// File: verif/spi_adc_model.sv
/* Behavioral ADC that shifts frame_mem out MSB first, changing sdi on falling sclk.
   The bit position restarts only when cs_n is released. */

`timescale 1ns/1ps

module spi_adc_model #(
    parameter int FRAME_LENGTH = 32
) (
    input  logic sclk,
    input  logic cs_n,
    output logic sdi
);

    // Frame bytes, filled by the testbench before each capture
    logic [7:0] frame_mem [0:FRAME_LENGTH-1];

    int bit_idx = 0;

    initial begin
        sdi = 1'b1;
    end

    always @(negedge sclk or posedge cs_n) begin
        if (cs_n) begin
            bit_idx = 0;
        end else begin
            // First falling edge after cs_n low carries bit 7 of byte 0
            if (bit_idx < FRAME_LENGTH * 8) begin
                sdi <= frame_mem[bit_idx / 8][7 - bit_idx % 8];
            end
            bit_idx = bit_idx + 1;
        end
    end

endmodule

// File: verif/adc_capture_tb.sv
/* Table-driven testbench for adc_capture_top with default parameters.
   Frame bytes come from an LFSR and are loaded into the ADC model before each capture. */

`timescale 1ns/1ps

module adc_capture_tb import adc_capture_pkg::*; ();

    localparam int ADR_W         = BUFFER_ADDR_WIDTH_DEFAULT - 1;
    localparam int WORDS         = FRAME_LENGTH_DEFAULT / 4;
    localparam int ACK_TIMEOUT   = 16;
    localparam int READY_TIMEOUT = 1000;

    // Register window sits above the buffer window
    localparam logic [ADR_W-1:0] REG_BASE    = 2 ** (ADR_W - 1);
    localparam logic [ADR_W-1:0] ADR_CONTROL = REG_BASE | REG_CONTROL;
    localparam logic [ADR_W-1:0] ADR_STATUS  = REG_BASE | REG_STATUS;
    localparam logic [ADR_W-1:0] ADR_COUNT   = REG_BASE | REG_FRAME_COUNT;
    localparam logic [ADR_W-1:0] ADR_UNDEF   = REG_BASE + 3;
    localparam logic [31:0]      DO_START    = 32'd1 << CTRL_START_BIT;
    localparam logic [31:0]      DO_CLEAR    = 32'd1 << CTRL_CLEAR_BIT;

    typedef enum logic [2:0] {
        OP_LOAD_FRAME, OP_WRITE, OP_READ_REG, OP_READ_FRAME, OP_WAIT_READY
    } op_e;

    typedef struct packed {
        op_e              op;
        logic [ADR_W-1:0] adr;
        logic [31:0]      wdata;
        logic [31:0]      expected;
    } step_t;

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [31:0]      wb_dat_w;
    logic [31:0]      wb_dat_r;
    logic             wb_ack;
    logic             sclk;
    logic             cs_n;
    logic             sdi;

    step_t       steps[$];
    logic [7:0]  frame_copy [0:FRAME_LENGTH_DEFAULT-1];
    logic [31:0] lfsr = 32'h7cea8202;
    int          error_count = 0;
    int          timeout_count = 0;

    adc_capture_top DUT (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .sclk(sclk), .cs_n(cs_n), .sdi(sdi)
    );

    spi_adc_model #(.FRAME_LENGTH(FRAME_LENGTH_DEFAULT)) adc_model (
        .sclk(sclk), .cs_n(cs_n), .sdi(sdi)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] status_value(input logic ready, input logic busy);
        logic [31:0] value;
        value = '0;
        value[STAT_READY_BIT] = ready;
        value[STAT_BUSY_BIT]  = busy;
        return value;
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED wb_dat_r status: got 0x%08h expected 0x%08h", got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED wb_dat_r frame count: got 0x%02h expected 0x%02h", got, exp);
            error_count++;
        end
    endtask

    task automatic check_pin(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%01h expected 0x%01h", what, got, exp);
            error_count++;
        end
    endtask

    task automatic add_step(input op_e op, input logic [ADR_W-1:0] adr,
                            input logic [31:0] wdata, input logic [31:0] expected);
        step_t s;
        s.op       = op;
        s.adr      = adr;
        s.wdata    = wdata;
        s.expected = expected;
        steps.push_back(s);
    endtask

    // One Wishbone classic cycle held until ack
    task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_ack) begin
            $display("Timeout: no Wishbone ack for address 0x%h", adr);
            timeout_count++;
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wait_ready();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[STAT_READY_BIT] && polls < READY_TIMEOUT && timeout_count == 0) begin
            wb_access(1'b0, ADR_STATUS, '0, status);
            polls++;
        end
        if (!status[STAT_READY_BIT] && timeout_count == 0) begin
            $display("Timeout: frame ready never seen in the status register");
            timeout_count++;
        end
    endtask

    // Fresh frame for the model with one LFSR step per bit
    task automatic load_frame();
        logic [7:0] value;
        for (int i = 0; i < FRAME_LENGTH_DEFAULT; i++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr  = lfsr_step(lfsr);
                value = {value[6:0], lfsr[0]};
            end
            frame_copy[i]          = value;
            adc_model.frame_mem[i] = value;
        end
    endtask

    task automatic check_frame();
        logic [31:0] rdata;
        logic [31:0] expected;
        for (int w = 0; w < WORDS && timeout_count == 0; w++) begin
            wb_access(1'b0, w[ADR_W-1:0], '0, rdata);
            expected = {frame_copy[4*w], frame_copy[4*w+1],
                        frame_copy[4*w+2], frame_copy[4*w+3]};
            check_word($sformatf("wb_dat_r buffer word %0d", w), rdata, expected);
        end
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rdata;
        case (s.op)
            OP_LOAD_FRAME: load_frame();
            OP_WRITE:      wb_access(1'b1, s.adr, s.wdata, rdata);
            OP_READ_FRAME: check_frame();
            OP_WAIT_READY: wait_ready();
            default: begin
                wb_access(1'b0, s.adr, '0, rdata);
                if (s.adr == ADR_STATUS) begin
                    check_status(rdata, s.expected);
                    // cs_n is low exactly while busy and sclk idles high
                    @(negedge clk);
                    check_pin("cs_n", cs_n, !s.expected[STAT_BUSY_BIT]);
                    if (!s.expected[STAT_BUSY_BIT])
                        check_pin("sclk", sclk, 1'b1);
                end else if (s.adr == ADR_COUNT) begin
                    check_count(rdata[7:0], s.expected[7:0]);
                end else begin
                    check_word("wb_dat_r register", rdata, s.expected);
                end
            end
        endcase
    endtask

    // Capture sequence with an optional second start while busy
    task automatic add_capture(input logic restart, input logic [31:0] count);
        add_step(OP_LOAD_FRAME, '0, '0, '0);
        add_step(OP_WRITE, ADR_CONTROL, DO_START, '0);
        add_step(OP_READ_REG, ADR_STATUS, '0, status_value(1'b0, 1'b1));
        if (restart) begin
            add_step(OP_WRITE, ADR_CONTROL, DO_START, '0);
            add_step(OP_READ_REG, ADR_STATUS, '0, status_value(1'b0, 1'b1));
        end
        add_step(OP_WAIT_READY, '0, '0, '0);
        add_step(OP_READ_REG, ADR_STATUS, '0, status_value(1'b1, 1'b0));
        add_step(OP_READ_FRAME, '0, '0, '0);
        add_step(OP_READ_REG, ADR_COUNT, '0, count);
    endtask

    task automatic build_table();
        add_step(OP_READ_REG, ADR_STATUS, '0, status_value(1'b0, 1'b0));
        add_step(OP_READ_REG, ADR_COUNT, '0, 32'd0);
        add_capture(1'b0, 32'd1);
        // Clearing ready leaves the buffer intact
        add_step(OP_WRITE, ADR_CONTROL, DO_CLEAR, '0);
        add_step(OP_READ_REG, ADR_STATUS, '0, status_value(1'b0, 1'b0));
        add_step(OP_READ_FRAME, '0, '0, '0);
        add_capture(1'b0, 32'd2);
        add_step(OP_WRITE, ADR_CONTROL, DO_CLEAR, '0);
        add_capture(1'b1, 32'd3);
        add_step(OP_READ_REG, ADR_UNDEF, '0, 32'd0);
        add_step(OP_WRITE, ADR_UNDEF, 32'hffff_ffff, '0);
        add_step(OP_READ_REG, ADR_STATUS, '0, status_value(1'b1, 1'b0));
        add_step(OP_READ_REG, ADR_COUNT, '0, 32'd3);
        add_step(OP_READ_REG, ADR_UNDEF, '0, 32'd0);
    endtask

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < steps.size() && timeout_count == 0; i++) begin
            run_step(steps[i]);
        end
        $display("Checks failed: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
design/adc_capture_pkg.sv
design/buffer_rd_if.sv
design/spi_sample_rx.sv
design/frame_buffer.sv
design/wb_frame_port.sv
design/adc_capture_top.sv
verif/spi_adc_model.sv
verif/adc_capture_tb.sv
